/* source/rename_params_pkg.sv */
package rename_params_pkg;

    // Architectural register space, RV32I
    localparam int ARCH_REGS = 32;
    localparam int ARCH_IDX_W = 5;

    // Physical register file size
    // Indices below ARCH_REGS are owned by the reset mapping
    localparam int PR_ENTRIES_DEF = 64;

    // In-flight window
    localparam int ROB_DEPTH_DEF = 8;

    // Dispatch buffering ahead of rename
    localparam int IQ_DEPTH_DEF = 4;

endpackage

/* source/rename_types_pkg.sv */
package rename_types_pkg;
    import rename_params_pkg::*;

    // Index width for a count of physical registers
    function automatic int pr_idx_w(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    // Index width for a count of ROB slots
    function automatic int rob_idx_w(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    // Physical index width carried in ROB entries
    localparam int PR_IDX_W = pr_idx_w(PR_ENTRIES_DEF);

    // Dispatched instruction, register fields only
    typedef struct packed {
        logic                  has_rd;
        logic [ARCH_IDX_W-1:0] rd;
        logic [ARCH_IDX_W-1:0] rs1;
        logic [ARCH_IDX_W-1:0] rs2;
    } arch_inst_t;

    // One ROB slot
    // old_prd goes back to the free list at commit
    typedef struct packed {
        logic                  done;
        logic                  has_rd;
        logic [ARCH_IDX_W-1:0] rd;
        logic [PR_IDX_W-1:0]   prd;
        logic [PR_IDX_W-1:0]   old_prd;
    } rob_entry_t;

endpackage

/* source/rob_alloc_if.sv */
`timescale 1ns/1ps

interface rob_alloc_if
import rename_params_pkg::*, rename_types_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
) ();

    // Allocation side
    logic                          alloc;
    rob_entry_t                    alloc_entry;
    logic                          full;
    logic [rob_idx_w(ROB_DEPTH)-1:0] next_id;

    // Commit side
    logic                          retire;
    logic                          head_valid;
    logic                          head_done;
    rob_entry_t                    head_entry;

    modport ctrl (
        output alloc, alloc_entry, retire,
        input  full, next_id, head_valid, head_done, head_entry
    );

    modport rob (
        input  alloc, alloc_entry, retire,
        output full, next_id, head_valid, head_done, head_entry
    );

endinterface

/* source/circular_queue.sv */
`timescale 1ns/1ps

module circular_queue #(
    parameter int  DEPTH           = 4,
    parameter type payload_t       = logic [7:0],
    parameter bit  INIT_SEQUENTIAL = 1'b0,
    parameter int  INIT_BASE       = 0
)
(
    input  logic     clk,
    input  logic     rst,

    input  logic     push,
    input  payload_t in_data,

    input  logic     pop,
    output payload_t out_data,

    output logic     empty,
    output logic     full
);

    localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W     = $clog2(DEPTH + 1);
    localparam int PAYLOAD_W = $bits(payload_t);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // Ring increment, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty    = (count_q == '0);
    assign full     = (count_q == CNT_W'(DEPTH));
    // Head visible before the pop edge
    assign out_data = mem[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            if (INIT_SEQUENTIAL) begin
                // Starts full, tail wrapped back onto head
                count_q <= CNT_W'(DEPTH);
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= payload_t'(PAYLOAD_W'(INIT_BASE + i));
                end
            end else begin
                count_q <= '0;
            end
        end else begin
            if (push) begin
                mem[tail_q] <= in_data;
                tail_q      <= ptr_next(tail_q);
            end
            if (pop) begin
                head_q <= ptr_next(head_q);
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Producer holds off on full unless the head leaves on the same edge
    assert property (@(posedge clk) disable iff (rst) (push && full) |-> pop)
        else $error("push into full queue");

    // Consumer only pops what is there
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from empty queue");

endmodule : circular_queue

/* source/register_alias_table.sv */
`timescale 1ns/1ps

module register_alias_table
import rename_params_pkg::*, rename_types_pkg::*;
#(
    parameter  int PR_ENTRIES = PR_ENTRIES_DEF,
    localparam int PRW        = pr_idx_w(PR_ENTRIES)
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Lookup ports, all combinational
    input  logic [ARCH_IDX_W-1:0] rs1,
    input  logic [ARCH_IDX_W-1:0] rs2,
    input  logic [ARCH_IDX_W-1:0] rd,
    output logic [PRW-1:0]        prs1,
    output logic [PRW-1:0]        prs2,
    output logic [PRW-1:0]        cur_prd,

    // New mapping for rd
    input  logic                  we,
    input  logic [PRW-1:0]        new_prd
);

    logic [PRW-1:0] map_q [ARCH_REGS];

    // Reads see the map before this edge's write
    assign prs1    = map_q[rs1];
    assign prs2    = map_q[rs2];
    // Mapping being replaced, kept in the ROB as old_prd
    assign cur_prd = map_q[rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity, x0 stays on p0 forever
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PRW'(i);
            end
        end else if (we && (rd != '0)) begin
            map_q[rd] <= new_prd;
        end
    end

    // Control filters out x0 destinations before they reach the map
    assert property (@(posedge clk) disable iff (rst) we |-> (rd != '0))
        else $error("RAT write to x0");

endmodule : register_alias_table

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer
import rename_params_pkg::*, rename_types_pkg::*;
#(
    parameter  int ROB_DEPTH  = ROB_DEPTH_DEF,
    parameter  int PR_ENTRIES = PR_ENTRIES_DEF,
    localparam int RIW        = rob_idx_w(ROB_DEPTH)
)
(
    input  logic           clk,
    input  logic           rst,

    rob_alloc_if.rob       alloc_bus,

    // Completion write port
    input  logic           wb_valid,
    input  logic [RIW-1:0] wb_rob_id
);

    rob_entry_t           entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] valid_q;
    logic [RIW-1:0]       head_q;
    logic [RIW-1:0]       tail_q;

    // Ring increment for non power of two depths
    function automatic logic [RIW-1:0] ptr_next(input logic [RIW-1:0] ptr);
        return (ptr == RIW'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Tail slot still occupied means no room
    assign alloc_bus.full       = valid_q[tail_q];
    assign alloc_bus.next_id    = tail_q;

    // Oldest instruction
    assign alloc_bus.head_valid = valid_q[head_q];
    assign alloc_bus.head_done  = valid_q[head_q] && entries[head_q].done;
    assign alloc_bus.head_entry = entries[head_q];

    // Occupancy and pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (alloc_bus.alloc) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= ptr_next(tail_q);
            end
            // Head and tail differ whenever both fire
            if (alloc_bus.retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= ptr_next(head_q);
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_bus.alloc) begin
            entries[tail_q]      <= alloc_bus.alloc_entry;
            entries[tail_q].done <= 1'b0;
        end
        // CDB style completion
        if (wb_valid) begin
            entries[wb_rob_id].done <= 1'b1;
        end
    end

    // Each live entry completes exactly once
    assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (valid_q[wb_rob_id] && !entries[wb_rob_id].done))
        else $error("completion for idle or finished ROB entry");

endmodule : reorder_buffer

/* source/rename_control.sv */
`timescale 1ns/1ps

module rename_control
import rename_params_pkg::*, rename_types_pkg::*;
#(
    parameter  int PR_ENTRIES = PR_ENTRIES_DEF,
    parameter  int ROB_DEPTH  = ROB_DEPTH_DEF,
    localparam int PRW        = pr_idx_w(PR_ENTRIES),
    localparam int RIW        = rob_idx_w(ROB_DEPTH)
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Instruction queue
    input  logic                  iq_empty,
    input  arch_inst_t            iq_inst,
    output logic                  iq_pop,

    // Free list
    input  logic                  fl_empty,
    input  logic [PRW-1:0]        fl_prd,
    output logic                  fl_pop,
    output logic                  fl_push,
    output logic [PRW-1:0]        fl_push_prd,

    // RAT
    output logic                  rat_we,
    output logic [ARCH_IDX_W-1:0] rat_rd,
    output logic [ARCH_IDX_W-1:0] rat_rs1,
    output logic [ARCH_IDX_W-1:0] rat_rs2,
    input  logic [PRW-1:0]        rat_prs1,
    input  logic [PRW-1:0]        rat_prs2,
    input  logic [PRW-1:0]        rat_cur_prd,

    rob_alloc_if.ctrl             alloc_bus,

    // Renamed record, one cycle after the rename edge
    output logic                  ren_valid,
    output logic [RIW-1:0]        ren_rob_id,
    output logic [PRW-1:0]        ren_prd,
    output logic [PRW-1:0]        ren_prs1,
    output logic [PRW-1:0]        ren_prs2,

    // Retired record, one cycle after the commit edge
    output logic                  commit_valid,
    output logic [ARCH_IDX_W-1:0] commit_rd,
    output logic [PRW-1:0]        commit_prd,
    output logic [PRW-1:0]        commit_old_prd,
    output logic                  commit_has_rd
);

    typedef struct packed {
        logic [RIW-1:0] rob_id;
        logic [PRW-1:0] prd;
        logic [PRW-1:0] prs1;
        logic [PRW-1:0] prs2;
    } renamed_inst_t;

    logic          needs_rd;
    logic          do_rename;
    logic          do_commit;
    renamed_inst_t ren_d;
    renamed_inst_t ren_q;
    rob_entry_t    commit_q;

    // x0 destination behaves as no destination
    assign needs_rd  = iq_inst.has_rd && (iq_inst.rd != '0);
    // Need an instruction, a ROB slot, and a register if it writes one
    assign do_rename = !iq_empty && !alloc_bus.full && (!fl_empty || !needs_rd);
    // Head retires the edge after it completes
    assign do_commit = alloc_bus.head_valid && alloc_bus.head_done;

    assign iq_pop  = do_rename;
    assign fl_pop  = do_rename && needs_rd;

    assign rat_we  = do_rename && needs_rd;
    assign rat_rd  = iq_inst.rd;
    assign rat_rs1 = iq_inst.rs1;
    assign rat_rs2 = iq_inst.rs2;

    // ROB entry for the instruction being renamed
    assign alloc_bus.alloc               = do_rename;
    assign alloc_bus.alloc_entry.done    = 1'b0;
    assign alloc_bus.alloc_entry.has_rd  = needs_rd;
    assign alloc_bus.alloc_entry.rd      = needs_rd ? iq_inst.rd : '0;
    assign alloc_bus.alloc_entry.prd     = needs_rd ? fl_prd : '0;
    assign alloc_bus.alloc_entry.old_prd = rat_cur_prd;

    // Commit returns the superseded mapping
    assign alloc_bus.retire = do_commit;
    assign fl_push          = do_commit && alloc_bus.head_entry.has_rd;
    assign fl_push_prd      = alloc_bus.head_entry.old_prd;

    always_comb begin
        ren_d.rob_id = alloc_bus.next_id;
        ren_d.prd    = needs_rd ? fl_prd : '0;
        ren_d.prs1   = rat_prs1;
        ren_d.prs2   = rat_prs2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid    <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            ren_valid    <= do_rename;
            commit_valid <= do_commit;
        end
    end

    // Payload only, qualified by the valids above
    always_ff @(posedge clk) begin
        if (do_rename) begin
            ren_q <= ren_d;
        end
        if (do_commit) begin
            commit_q <= alloc_bus.head_entry;
        end
    end

    assign ren_rob_id     = ren_q.rob_id;
    assign ren_prd        = ren_q.prd;
    assign ren_prs1       = ren_q.prs1;
    assign ren_prs2       = ren_q.prs2;

    assign commit_rd      = commit_q.rd;
    assign commit_prd     = commit_q.prd;
    assign commit_old_prd = commit_q.old_prd;
    assign commit_has_rd  = commit_q.has_rd;

endmodule : rename_control

/* source/rename_top.sv */
`timescale 1ns/1ps

module rename_top
import rename_params_pkg::*, rename_types_pkg::*;
#(
    parameter  int PR_ENTRIES = PR_ENTRIES_DEF,
    parameter  int ROB_DEPTH  = ROB_DEPTH_DEF,
    parameter  int IQ_DEPTH   = IQ_DEPTH_DEF,
    localparam int PRW        = pr_idx_w(PR_ENTRIES),
    localparam int RIW        = rob_idx_w(ROB_DEPTH)
)
(
    input  logic                  clk,
    input  logic                  rst,

    // Dispatch
    input  logic                  disp_valid,
    input  arch_inst_t            disp_inst,
    output logic                  disp_ready,

    // Rename result
    output logic                  ren_valid,
    output logic [RIW-1:0]        ren_rob_id,
    output logic [PRW-1:0]        ren_prd,
    output logic [PRW-1:0]        ren_prs1,
    output logic [PRW-1:0]        ren_prs2,

    // Completion
    input  logic                  wb_valid,
    input  logic [RIW-1:0]        wb_rob_id,

    // Commit
    output logic                  commit_valid,
    output logic [ARCH_IDX_W-1:0] commit_rd,
    output logic [PRW-1:0]        commit_prd,
    output logic [PRW-1:0]        commit_old_prd,
    output logic                  commit_has_rd
);

    // Instruction queue
    arch_inst_t iq_inst;
    logic       iq_empty, iq_full, iq_pop;

    // Free list
    logic [PRW-1:0] fl_prd, fl_push_prd;
    logic           fl_empty, fl_pop, fl_push;

    // RAT lookups and update
    logic                  rat_we;
    logic [ARCH_IDX_W-1:0] rat_rd, rat_rs1, rat_rs2;
    logic [PRW-1:0]        rat_prs1, rat_prs2, rat_cur_prd;

    rob_alloc_if #(.ROB_DEPTH(ROB_DEPTH)) alloc_bus ();

    assign disp_ready = !iq_full;

    circular_queue #(.DEPTH(IQ_DEPTH), .payload_t(arch_inst_t)) inst_queue (
        .clk(clk), .rst(rst),
        .push(disp_valid && disp_ready), .in_data(disp_inst),
        .pop(iq_pop), .out_data(iq_inst),
        .empty(iq_empty), .full(iq_full)
    );

    // Holds every register not named by the reset mapping
    circular_queue #(
        .DEPTH(PR_ENTRIES - ARCH_REGS), .payload_t(logic [PRW-1:0]),
        .INIT_SEQUENTIAL(1'b1), .INIT_BASE(ARCH_REGS)
    ) free_list (
        .clk(clk), .rst(rst),
        .push(fl_push), .in_data(fl_push_prd),
        .pop(fl_pop), .out_data(fl_prd),
        .empty(fl_empty), .full()
    );

    // New mapping is the free list head popped on the same edge
    register_alias_table #(.PR_ENTRIES(PR_ENTRIES)) rat_i (
        .clk(clk), .rst(rst),
        .rs1(rat_rs1), .rs2(rat_rs2), .rd(rat_rd),
        .prs1(rat_prs1), .prs2(rat_prs2), .cur_prd(rat_cur_prd),
        .we(rat_we), .new_prd(fl_prd)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .PR_ENTRIES(PR_ENTRIES)) rob_i (
        .clk(clk), .rst(rst),
        .alloc_bus(alloc_bus.rob),
        .wb_valid(wb_valid), .wb_rob_id(wb_rob_id)
    );

    rename_control #(.PR_ENTRIES(PR_ENTRIES), .ROB_DEPTH(ROB_DEPTH)) control_i (
        .clk(clk), .rst(rst),
        .iq_empty(iq_empty), .iq_inst(iq_inst), .iq_pop(iq_pop),
        .fl_empty(fl_empty), .fl_prd(fl_prd), .fl_pop(fl_pop),
        .fl_push(fl_push), .fl_push_prd(fl_push_prd),
        .rat_we(rat_we), .rat_rd(rat_rd), .rat_rs1(rat_rs1), .rat_rs2(rat_rs2),
        .rat_prs1(rat_prs1), .rat_prs2(rat_prs2), .rat_cur_prd(rat_cur_prd),
        .alloc_bus(alloc_bus.ctrl),
        .ren_valid(ren_valid), .ren_rob_id(ren_rob_id), .ren_prd(ren_prd),
        .ren_prs1(ren_prs1), .ren_prs2(ren_prs2),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_prd(commit_prd),
        .commit_old_prd(commit_old_prd), .commit_has_rd(commit_has_rd)
    );

endmodule : rename_top

/* sim/rename_tb.sv */
`timescale 1ns/1ps

module rename_tb
import rename_params_pkg::*, rename_types_pkg::*;
();

    localparam int PR_ENTRIES      = PR_ENTRIES_DEF;
    localparam int ROB_DEPTH       = ROB_DEPTH_DEF;
    localparam int IQ_DEPTH        = IQ_DEPTH_DEF;
    localparam int PRW             = pr_idx_w(PR_ENTRIES);
    localparam int RIW             = rob_idx_w(ROB_DEPTH);
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    // Instructions per test, in run order
    localparam int TOTAL_LENGTH    = 6 + 8 + 20 + 40 + 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_LENGTH * 40;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  disp_valid, disp_ready;
    arch_inst_t            disp_inst;
    logic                  ren_valid, wb_valid;
    logic [RIW-1:0]        ren_rob_id, wb_rob_id;
    logic [PRW-1:0]        ren_prd, ren_prs1, ren_prs2;
    logic                  commit_valid, commit_has_rd;
    logic [ARCH_IDX_W-1:0] commit_rd;
    logic [PRW-1:0]        commit_prd, commit_old_prd;

    // Shadow model: map, free FIFO, dispatched and in-flight rings
    logic [PRW-1:0] map_m [ARCH_REGS];
    logic [PRW-1:0] free_m [64];
    logic [5:0]     free_rd, free_wr;
    arch_inst_t     disp_m [64];
    logic [5:0]     disp_rd, disp_wr;
    rob_entry_t     rob_m [16];
    logic [3:0]     rob_rd, rob_wr;
    logic [RIW-1:0] ren_id_m;

    // Expected values for the next observed rename and commit
    arch_inst_t     next_inst;
    logic           exp_needs_rd;
    logic [PRW-1:0] exp_prd, exp_prs1, exp_prs2, exp_old_prd;
    rob_entry_t     exp_commit;
    int             pending_m, iq_m, inflight_m, free_cnt_m;

    // Stimulus state
    int             seed = 71549;
    int             errors = 0;
    int             errors_at_start;
    int             tests_run = 0;
    int             accepted, renamed, committed;
    arch_inst_t     send_q [$];
    logic [RIW-1:0] open_ids [$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    rename_top #(.PR_ENTRIES(PR_ENTRIES), .ROB_DEPTH(ROB_DEPTH), .IQ_DEPTH(IQ_DEPTH)) rename_top_i (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_inst(disp_inst), .disp_ready(disp_ready),
        .ren_valid(ren_valid), .ren_rob_id(ren_rob_id), .ren_prd(ren_prd),
        .ren_prs1(ren_prs1), .ren_prs2(ren_prs2),
        .wb_valid(wb_valid), .wb_rob_id(wb_rob_id),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_prd(commit_prd),
        .commit_old_prd(commit_old_prd), .commit_has_rd(commit_has_rd)
    );

    assign next_inst    = disp_m[disp_rd];
    // x0 destination counts as none
    assign exp_needs_rd = next_inst.has_rd && (next_inst.rd != '0);
    assign exp_prd      = exp_needs_rd ? free_m[free_rd] : '0;
    assign exp_prs1     = map_m[next_inst.rs1];
    assign exp_prs2     = map_m[next_inst.rs2];
    assign exp_old_prd  = map_m[next_inst.rd];
    assign exp_commit   = rob_m[rob_rd];
    assign pending_m    = int'(6'(disp_wr - disp_rd));
    // Rename seen this cycle already left the queue one edge ago
    assign iq_m         = pending_m - int'(ren_valid);
    assign inflight_m   = int'(4'(rob_wr - rob_rd));
    assign free_cnt_m   = int'(6'(free_wr - free_rd));

    // Model follows observed outputs, one edge behind the DUT
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_m[i] <= PRW'(i);
            end
            for (int i = 0; i < PR_ENTRIES - ARCH_REGS; i++) begin
                free_m[i] <= PRW'(ARCH_REGS + i);
            end
            free_rd  <= '0;
            free_wr  <= 6'(PR_ENTRIES - ARCH_REGS);
            disp_rd  <= '0;
            disp_wr  <= '0;
            rob_rd   <= '0;
            rob_wr   <= '0;
            ren_id_m <= '0;
        end else begin
            if (disp_valid && disp_ready) begin
                disp_m[disp_wr] <= disp_inst;
                disp_wr         <= disp_wr + 1'b1;
            end
            if (ren_valid) begin
                disp_rd               <= disp_rd + 1'b1;
                ren_id_m              <= (ren_id_m == RIW'(ROB_DEPTH - 1)) ? '0 : ren_id_m + 1'b1;
                rob_m[rob_wr].done    <= 1'b0;
                rob_m[rob_wr].has_rd  <= exp_needs_rd;
                rob_m[rob_wr].rd      <= exp_needs_rd ? next_inst.rd : '0;
                rob_m[rob_wr].prd     <= exp_prd;
                rob_m[rob_wr].old_prd <= exp_old_prd;
                rob_wr                <= rob_wr + 1'b1;
                if (exp_needs_rd) begin
                    free_rd              <= free_rd + 1'b1;
                    map_m[next_inst.rd] <= exp_prd;
                end
            end
            if (commit_valid) begin
                rob_rd <= rob_rd + 1'b1;
                // Superseded mapping returns to the tail
                if (exp_commit.has_rd) begin
                    free_m[free_wr] <= exp_commit.old_prd;
                    free_wr         <= free_wr + 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) ren_valid |-> (pending_m > 0))
        else report_problem("a rename appeared with no dispatched instruction waiting");
    assert property (@(posedge clk) disable iff (rst) ren_valid |-> (ren_rob_id == ren_id_m))
        else report_value("ren_rob_id out of allocation order");
    assert property (@(posedge clk) disable iff (rst)
        (ren_valid && exp_needs_rd) |-> (free_cnt_m > 0))
        else report_problem("a rename took a register from an empty free list");
    assert property (@(posedge clk) disable iff (rst) ren_valid |-> (ren_prd == exp_prd))
        else report_value("ren_prd differs from free list order");
    assert property (@(posedge clk) disable iff (rst)
        ren_valid |-> ((ren_prs1 == exp_prs1) && (ren_prs2 == exp_prs2)))
        else report_value("source mapping differs from alias map");
    assert property (@(posedge clk) disable iff (rst) ren_valid |-> (inflight_m < ROB_DEPTH))
        else report_problem("an instruction renamed while the ROB was full");
    assert property (@(posedge clk) disable iff (rst) disp_ready == (iq_m < IQ_DEPTH))
        else report_value("disp_ready does not match queue occupancy");
    assert property (@(posedge clk) disable iff (rst) commit_valid |-> (inflight_m > 0))
        else report_problem("a commit came with nothing in flight");
    assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> (commit_has_rd == exp_commit.has_rd))
        else report_value("commit_has_rd differs from dispatch order");
    assert property (@(posedge clk) disable iff (rst)
        (commit_valid && commit_has_rd) |-> ((commit_rd == exp_commit.rd)
            && (commit_prd == exp_commit.prd) && (commit_old_prd == exp_commit.old_prd)))
        else report_value("commit registers differ from dispatch order");

    task automatic report_value(input string msg);
        errors++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Problem at %0t ns: %s", $time, msg);
    endtask

    function automatic arch_inst_t make_inst(input logic has_rd, input int rd,
                                             input int rs1, input int rs2);
        arch_inst_t inst;
        inst.has_rd = has_rd;
        inst.rd     = ARCH_IDX_W'(rd);
        inst.rs1    = ARCH_IDX_W'(rs1);
        inst.rs2    = ARCH_IDX_W'(rs2);
        return inst;
    endfunction

    // Forced destinations avoid x0 so every one takes a register
    function automatic arch_inst_t random_inst(input bit force_rd);
        arch_inst_t inst;
        inst.has_rd = force_rd || (($random(seed) & 7) != 0);
        inst.rd     = force_rd ? ARCH_IDX_W'(1 + ({$random(seed)} % 31))
                               : ARCH_IDX_W'($random(seed));
        inst.rs1    = ARCH_IDX_W'($random(seed));
        inst.rs2    = ARCH_IDX_W'($random(seed));
        return inst;
    endfunction

    // One clock: observe at the falling edge, then drive dispatch and a random completion
    task automatic step(input bit completions);
        int             k;
        bit             fire;
        bit             seen_ren;
        bit             seen_commit;
        logic [RIW-1:0] seen_id;
        @(negedge clk);
        fire        = disp_valid && disp_ready;
        seen_ren    = ren_valid;
        seen_commit = commit_valid;
        seen_id     = ren_rob_id;
        @(posedge clk);
        if (seen_ren) begin
            renamed++;
            open_ids.push_back(seen_id);
        end
        if (seen_commit) begin
            committed++;
        end
        if (fire) begin
            accepted++;
            send_q.delete(0);
        end
        if (send_q.size() > 0) begin
            disp_valid <= 1'b1;
            disp_inst  <= send_q[0];
        end else begin
            disp_valid <= 1'b0;
        end
        if (completions && (open_ids.size() > 0) && (($random(seed) & 3) != 0)) begin
            k = {$random(seed)} % open_ids.size();
            wb_valid  <= 1'b1;
            wb_rob_id <= open_ids[k];
            open_ids.delete(k);
        end else begin
            wb_valid <= 1'b0;
        end
    endtask

    // Run until everything accepted has committed
    task automatic drain();
        while ((send_q.size() > 0) || disp_valid || (committed < accepted)) begin
            step(1'b1);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
        accepted        = 0;
        renamed         = 0;
        committed       = 0;
    endtask

    task automatic end_test(input int num, input string name);
        assert (renamed == accepted)
            else report_problem($sformatf("%0d accepted but %0d renamed", accepted, renamed));
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", num, name, errors - errors_at_start);
        end
    endtask

    initial begin
        rst        = 1'b1;
        disp_valid = 1'b0;
        disp_inst  = '0;
        wb_valid   = 1'b0;
        wb_rob_id  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!ren_valid && !commit_valid && disp_ready)
            else report_problem("outputs were not idle after reset");

        // Chain of writers, each reading the previous destination
        start_test();
        for (int i = 0; i < 6; i++) begin
            send_q.push_back(make_inst(1'b1, i + 1, i, i + 1));
        end
        drain();
        end_test(1, "fresh allocation");

        // No destination, x0 destination, and real ones mixed
        start_test();
        send_q.push_back(make_inst(1'b1, 0, 1, 2));
        send_q.push_back(make_inst(1'b0, 9, 3, 4));
        send_q.push_back(make_inst(1'b1, 7, 0, 1));
        send_q.push_back(make_inst(1'b0, 0, 7, 2));
        send_q.push_back(make_inst(1'b1, 0, 7, 7));
        send_q.push_back(make_inst(1'b1, 8, 7, 1));
        send_q.push_back(make_inst(1'b0, 5, 8, 8));
        send_q.push_back(make_inst(1'b1, 9, 8, 7));
        drain();
        end_test(2, "rd zero");

        start_test();
        repeat (20) send_q.push_back(random_inst(1'b0));
        drain();
        end_test(3, "in-order commit");

        // Enough writers to wrap the free list
        start_test();
        repeat (40) send_q.push_back(random_inst(1'b1));
        drain();
        end_test(4, "register reuse");

        // Completions held off until the ROB and queue fill
        start_test();
        repeat (16) send_q.push_back(random_inst(1'b1));
        repeat (40) step(1'b0);
        assert (renamed == ROB_DEPTH)
            else report_problem("renames did not stop at a full ROB");
        assert (!disp_ready && (accepted == ROB_DEPTH + IQ_DEPTH))
            else report_problem("dispatch was not held off by a full queue");
        drain();
        end_test(5, "back-pressure");

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule : rename_tb

/* rename_top.f */
source/rename_params_pkg.sv
source/rename_types_pkg.sv
source/rob_alloc_if.sv
source/circular_queue.sv
source/register_alias_table.sv
source/reorder_buffer.sv
source/rename_control.sv
source/rename_top.sv
sim/rename_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the rename core testbench with Verilator and run it.
# Pass only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module rename_tb \
    -f rename_top.f -o rename_sim \
    && ./obj_dir/rename_sim | tee /dev/stderr | grep "Done: no errors" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
